// File: hw/uart_pkg.sv
// UART peripheral shared definitions.
// Register map, bus access codes, divider reset value and FSM state encodings.
`default_nettype none

package uart_pkg;

    // Register offsets within the peripheral's 64-byte window.
    localparam logic [5:0] ADDR_DATA    = 6'h0;  // Write sends, read consumes.
    localparam logic [5:0] ADDR_STATUS  = 6'h4;  // Bit 0 tx busy, bit 1 rx valid.
    localparam logic [5:0] ADDR_DIVIDER = 6'h8;  // Bit period in clock cycles.

    // Encodings of data_write_n and data_read_n.
    localparam logic [1:0] ACCESS_BYTE = 2'b00;
    localparam logic [1:0] ACCESS_HALF = 2'b01;
    localparam logic [1:0] ACCESS_WORD = 2'b10;
    localparam logic [1:0] ACCESS_NONE = 2'b11;  // No transfer this cycle.

    // 115200 baud from a 64 MHz clock.
    localparam logic [15:0] DIVIDER_RESET = 16'd555;

    // Transmitter states.
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    // Receiver states.
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

// File: hw/uart_baud_timer.sv
// UART bit-period timer.
// Counts one bit period while run is high and flags the mid-bit and last cycle.
`default_nettype none

module uart_baud_timer #(
    parameter int DIVIDER_REG_LEN = 13  // Width of the divider and the counter.
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,           // High while a frame is in progress.
    input  logic [DIVIDER_REG_LEN-1:0] baud_divider,  // Clock cycles per bit.
    output logic                       mid_tick,      // Pulse half way through a bit.
    output logic                       bit_tick       // Pulse on the last cycle of a bit.
);

    logic [DIVIDER_REG_LEN-1:0] count;       // Position within the current bit.
    logic [DIVIDER_REG_LEN-1:0] last_count;  // Final count of a bit period.
    logic [DIVIDER_REG_LEN-1:0] half_count;  // Count at which the line is sampled.

    assign last_count = baud_divider - 1'b1;
    assign half_count = baud_divider >> 1;  // Rounds down for odd dividers.

    // The count sits at zero while idle, so the first bit of a frame always
    // starts a full period from the cycle in which run rises.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count == last_count) begin
            count <= '0;  // Wrap into the next bit.
        end else begin
            count <= count + 1'b1;
        end
    end

    // Ticks are gated with run so an idle counter never fires them,
    // even when the divider is small enough that half_count is zero.
    assign mid_tick = run && (count == half_count);
    assign bit_tick = run && (count == last_count);

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// UART transmitter.
// Serialises one byte as an 8N1 frame, advancing one bit on each bit_tick.
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,  // One-cycle request to send tx_data.
    input  logic [7:0] tx_data,
    input  logic       bit_tick,  // End of the current bit period.
    output logic       run,       // Keeps the bit timer counting.
    output logic       txd,       // Serial output, idles high.
    output logic       tx_busy    // High from start bit to end of stop bit.
);

    import uart_pkg::*;

    tx_state_t  state;
    logic [2:0] bit_idx;  // Data bit currently on the line.
    logic [7:0] shift;    // Remaining data bits, next one in bit 0.
    logic       load;     // Accept a new byte this cycle.

    assign load = tx_start && (state == TX_IDLE);  // Requests while busy are dropped.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_idx <= 3'd0;
            txd     <= 1'b1;  // Line is marking when idle.
        end else begin
            case (state)
                TX_IDLE: if (load) begin
                    state   <= TX_START;
                    bit_idx <= 3'd0;
                    txd     <= 1'b0;  // Start bit.
                end
                TX_START: if (bit_tick) begin
                    state <= TX_DATA;
                    txd   <= shift[0];  // Bit 0 goes out first.
                end
                TX_DATA: if (bit_tick) begin
                    if (bit_idx == 3'd7) begin
                        state <= TX_STOP;
                        txd   <= 1'b1;  // Stop bit.
                    end else begin
                        bit_idx <= bit_idx + 3'd1;
                        txd     <= shift[0];
                    end
                end
                TX_STOP: if (bit_tick) begin
                    state <= TX_IDLE;  // Line is already high for idle.
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // The byte is captured at the start and shifted right as each bit leaves.
    always_ff @(posedge clk) begin
        if (load) begin
            shift <= tx_data;
        end else if (bit_tick && (state == TX_START || state == TX_DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    assign tx_busy = (state != TX_IDLE);
    assign run     = tx_busy;  // The timer runs for the whole frame.

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
// UART receiver.
// Samples 8N1 frames at mid-bit and holds the last good byte until it is read.
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,       // Serial input, already synchronised.
    input  logic       rx_read,   // One-cycle pulse when the byte is consumed.
    input  logic       mid_tick,  // Middle of the current bit period.
    output logic       run,       // Keeps the bit timer counting.
    output logic [7:0] rx_data,   // Last byte received with a valid stop bit.
    output logic       rx_valid,  // rx_data has not been read yet.
    output logic       rts        // High while a byte waits.
);

    import uart_pkg::*;

    rx_state_t  state;
    logic [2:0] bit_idx;  // Data bit being sampled.
    logic [7:0] shift;    // Bits arrive LSB first and enter at the top.
    logic       sample;   // Shift in a data bit this cycle.
    logic       commit;   // Stop bit was good, store the byte.

    assign sample = mid_tick && (state == RX_DATA);
    assign commit = mid_tick && (state == RX_STOP) && rxd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= RX_IDLE;
            bit_idx <= 3'd0;
        end else begin
            case (state)
                // A falling line may be a start bit; the timer starts from here.
                RX_IDLE: if (!rxd) begin
                    state <= RX_START;
                end
                RX_START: if (mid_tick) begin
                    // A glitch shorter than half a bit is ignored.
                    if (!rxd) begin
                        state   <= RX_DATA;
                        bit_idx <= 3'd0;
                    end else begin
                        state <= RX_IDLE;
                    end
                end
                RX_DATA: if (mid_tick) begin
                    if (bit_idx == 3'd7) begin
                        state <= RX_STOP;
                    end else begin
                        bit_idx <= bit_idx + 3'd1;
                    end
                end
                // Back to idle at the middle of the stop bit whether or not
                // it was good, so the next start edge is caught in time.
                RX_STOP: if (mid_tick) begin
                    state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            shift <= {rxd, shift[7:1]};
        end
    end

    // A new byte overwrites one that was never read.
    always_ff @(posedge clk) begin
        if (commit) begin
            rx_data <= shift;
        end
    end

    // A byte arriving in the same cycle as a read keeps the flag set.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else if (commit) begin
            rx_valid <= 1'b1;
        end else if (rx_read) begin
            rx_valid <= 1'b0;
        end
    end

    assign run = (state != RX_IDLE);
    assign rts = rx_valid;  // Asks the far end to pause while a byte waits.

endmodule

`default_nettype wire

// File: hw/uart_regs.sv
// UART register block.
// Decodes bus accesses, holds the baud divider and muxes read data.
`default_nettype none

module uart_regs #(
    parameter int DIVIDER_REG_LEN = 13  // Width of the baud divider.
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [5:0]                 address,
    input  logic [31:0]                data_in,       // Low 8, 16 or 32 bits valid on write.
    input  logic [1:0]                 data_write_n,  // Access size, or none.
    input  logic [1:0]                 data_read_n,   // Access size, or none.
    input  logic                       tx_busy,
    input  logic                       rx_valid,
    input  logic [7:0]                 rx_data,
    output logic [31:0]                data_out,
    output logic                       user_interrupt,
    output logic [DIVIDER_REG_LEN-1:0] baud_divider,
    output logic                       tx_start,
    output logic [7:0]                 tx_data,
    output logic                       rx_read
);

    import uart_pkg::*;

    // Bits of the divider that a byte write reaches.
    localparam logic [DIVIDER_REG_LEN-1:0] BYTE_MASK = DIVIDER_REG_LEN'(8'hff);

    logic                       div_write;  // Any write to the divider.
    logic                       div_wide;   // The write covers the upper lanes too.
    logic [DIVIDER_REG_LEN-1:0] wr_value;

    assign div_write = (address == ADDR_DIVIDER) && (data_write_n != ACCESS_NONE);
    assign div_wide  = (data_write_n == ACCESS_HALF) || (data_write_n == ACCESS_WORD);
    assign wr_value  = data_in[DIVIDER_REG_LEN-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            baud_divider <= DIVIDER_REG_LEN'(DIVIDER_RESET);
        end else if (div_write) begin
            if (div_wide) begin
                baud_divider <= wr_value;  // Upper bits of the bus are dropped.
            end else begin
                baud_divider <= (baud_divider & ~BYTE_MASK) | (wr_value & BYTE_MASK);
            end
        end
    end

    // Each bus access to the data register makes a one-cycle strobe.
    assign tx_start = (address == ADDR_DATA) && (data_write_n != ACCESS_NONE);
    assign tx_data  = data_in[7:0];
    assign rx_read  = (address == ADDR_DATA) && (data_read_n != ACCESS_NONE);

    // Reads complete in the same cycle.
    always_comb begin
        case (address)
            ADDR_DATA:    data_out = {24'd0, rx_data};
            ADDR_STATUS:  data_out = {30'd0, rx_valid, tx_busy};
            ADDR_DIVIDER: data_out = 32'(baud_divider);
            default:      data_out = 32'd0;
        endcase
    end

    // Raised when there is a byte to read or room to send one.
    assign user_interrupt = rx_valid || !tx_busy;

endmodule

`default_nettype wire

// File: hw/uart_periph.sv
// UART peripheral top level.
// One register block driving a transmitter and a receiver, each with its own timer.
`default_nettype none

module uart_periph #(
    parameter int DIVIDER_REG_LEN = 13  // 13 bits reach 9600 baud at 64 MHz.
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  address,
    input  logic [31:0] data_in,
    input  logic [1:0]  data_write_n,
    input  logic [1:0]  data_read_n,
    output logic [31:0] data_out,
    output logic        user_interrupt,
    input  logic        rxd,
    output logic        txd,
    output logic        rts
);

    logic [DIVIDER_REG_LEN-1:0] baud_divider;  // Shared by both timers.
    logic                       tx_start;
    logic [7:0]                 tx_data;
    logic                       tx_busy;
    logic                       tx_run;
    logic                       tx_bit_tick;
    logic                       rx_read;
    logic [7:0]                 rx_data;
    logic                       rx_valid;
    logic                       rx_run;
    logic                       rx_mid_tick;

    uart_regs #(.DIVIDER_REG_LEN(DIVIDER_REG_LEN)) regs (
        .clk(clk), .rst_n(rst_n), .address(address), .data_in(data_in),
        .data_write_n(data_write_n), .data_read_n(data_read_n),
        .tx_busy(tx_busy), .rx_valid(rx_valid), .rx_data(rx_data),
        .data_out(data_out), .user_interrupt(user_interrupt),
        .baud_divider(baud_divider), .tx_start(tx_start), .tx_data(tx_data),
        .rx_read(rx_read)
    );

    // The transmitter only needs the end of each bit.
    uart_baud_timer #(.DIVIDER_REG_LEN(DIVIDER_REG_LEN)) tx_timer (
        .clk(clk), .rst_n(rst_n), .run(tx_run), .baud_divider(baud_divider),
        .mid_tick(), .bit_tick(tx_bit_tick)
    );

    uart_tx tx (
        .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_data(tx_data),
        .bit_tick(tx_bit_tick), .run(tx_run), .txd(txd), .tx_busy(tx_busy)
    );

    // The receiver samples at mid-bit only.
    uart_baud_timer #(.DIVIDER_REG_LEN(DIVIDER_REG_LEN)) rx_timer (
        .clk(clk), .rst_n(rst_n), .run(rx_run), .baud_divider(baud_divider),
        .mid_tick(rx_mid_tick), .bit_tick()
    );

    uart_rx rx (
        .clk(clk), .rst_n(rst_n), .rxd(rxd), .rx_read(rx_read),
        .mid_tick(rx_mid_tick), .run(rx_run), .rx_data(rx_data),
        .rx_valid(rx_valid), .rts(rts)
    );

endmodule

`default_nettype wire

// File: verif/uart_periph_tb.sv
// Testbench for the UART peripheral.
// Runs a table of bus and serial tests, with an optional txd to rxd loop-back.
`default_nettype none

module uart_periph_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import uart_pkg::*;

    localparam int SERIAL_DIV = 8;  // Divider used by every serial test.

    typedef enum {OP_RESET, OP_DIV_BYTE, OP_DIV_HALF, OP_DIV_WORD,
                  OP_TX, OP_RX, OP_OVERRUN, OP_LOOP} op_t;

    typedef struct {
        string       name;
        op_t         op;
        logic [7:0]  data;      // Serial payload.
        logic [31:0] div;       // Value put on data_in for divider writes.
        logic        stop;      // Stop-bit level sent by the driver.
        logic [31:0] expected;
    } entry_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [5:0]  address;
    logic [31:0] data_in;
    logic [1:0]  data_write_n;
    logic [1:0]  data_read_n;
    logic [31:0] data_out;
    logic        user_interrupt;
    logic        rxd;
    logic        txd;
    logic        rts;
    logic        rxd_drv;    // Serial line from the driver.
    logic        loop_back;  // When set, the receiver listens to txd.
    entry_t      tests[$];
    integer      seed;

    assign rxd = loop_back ? txd : rxd_drv;

    always #10 clk = ~clk;  // 50 MHz.

    uart_periph #(.DIVIDER_REG_LEN(13)) UUT (
        .clk(clk), .rst_n(rst_n), .address(address), .data_in(data_in),
        .data_write_n(data_write_n), .data_read_n(data_read_n), .data_out(data_out),
        .user_interrupt(user_interrupt), .rxd(rxd), .txd(txd), .rts(rts)
    );

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic add_entry(input string name, input op_t op, input logic [7:0] data,
                             input logic [31:0] div, input logic stop,
                             input logic [31:0] expected);
        entry_t e;
        e = '{name, op, data, div, stop, expected};
        tests.push_back(e);
    endtask

    // One bus cycle; the strobe is seen by the DUT on the edge that follows.
    task automatic bus_write(input logic [5:0] addr, input logic [31:0] value,
                             input logic [1:0] size);
        @(posedge clk);
        #2 address = addr;
        data_in = value;
        data_write_n = size;
        @(posedge clk);
        #2 data_write_n = ACCESS_NONE;
    endtask

    task automatic bus_read(input logic [5:0] addr, output logic [31:0] value);
        @(posedge clk);
        #2 address = addr;
        data_read_n = ACCESS_WORD;
        #1 value = data_out;  // Read data is combinational.
        @(posedge clk);
        #2 data_read_n = ACCESS_NONE;
    endtask

    // Polls the status register until one bit reaches a level.
    task automatic wait_status(input int bit_idx, input logic level, input int max_reads);
        logic [31:0] word;
        int          n;
        n = 0;
        do begin
            bus_read(ADDR_STATUS, word);
            n++;
        end while (word[bit_idx] !== level && n < max_reads);
        if (word[bit_idx] !== level) begin
            $display("Status bit %0d did not become %b after %0d reads", bit_idx, level, n);
            abort_run();
        end
    endtask

    task automatic send_frame(input logic [7:0] value, input logic stop);
        logic [9:0] bits;
        bits = {stop, value, 1'b0};  // Start bit goes first.
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #2 rxd_drv = bits[i];
            repeat (SERIAL_DIV - 1) @(posedge clk);
        end
        @(posedge clk);
        #2 rxd_drv = 1'b1;
    endtask

    // Samples txd in the middle of each bit period from the write edge.
    task automatic capture_frame(input string name, output logic [7:0] value);
        repeat (SERIAL_DIV / 2) @(posedge clk);
        #2 check_bit({name, " start bit"}, 1'b0, txd);
        for (int i = 0; i < 8; i++) begin
            repeat (SERIAL_DIV) @(posedge clk);
            #2 value[i] = txd;
        end
        repeat (SERIAL_DIV) @(posedge clk);
        #2 check_bit({name, " stop bit"}, 1'b1, txd);
        address = ADDR_STATUS;  // Peek at status without a bus strobe.
        #1 check_bit({name, " busy in frame"}, 1'b1, data_out[0]);
        check_bit({name, " interrupt in frame"}, 1'b0, user_interrupt);  // No byte waits.
        repeat (SERIAL_DIV / 2) @(posedge clk);
        #2 check_bit({name, " busy after frame"}, 1'b0, data_out[0]);
    endtask

    task automatic run_entry(input entry_t t);
        logic [31:0] word;
        logic [7:0]  got;
        case (t.op)
            OP_RESET: begin
                bus_read(ADDR_DIVIDER, word);
                check_word(t.name, t.expected, word);
                bus_read(ADDR_STATUS, word);
                check_word({t.name, " status"}, 32'd0, word);
                check_bit({t.name, " txd"}, 1'b1, txd);
                check_bit({t.name, " rts"}, 1'b0, rts);
                check_bit({t.name, " interrupt"}, 1'b1, user_interrupt);
            end
            OP_DIV_BYTE, OP_DIV_HALF, OP_DIV_WORD: begin
                bus_write(ADDR_DIVIDER, t.div, (t.op == OP_DIV_BYTE) ? ACCESS_BYTE :
                          (t.op == OP_DIV_HALF) ? ACCESS_HALF : ACCESS_WORD);
                bus_read(ADDR_DIVIDER, word);
                check_word(t.name, t.expected, word);
            end
            OP_TX: begin
                bus_write(ADDR_DATA, {24'd0, t.data}, ACCESS_BYTE);
                capture_frame(t.name, got);
                check_byte(t.name, t.expected[7:0], got);
            end
            OP_RX, OP_OVERRUN: begin
                if (t.op == OP_OVERRUN) send_frame(~t.data, 1'b1);  // Never read.
                send_frame(t.data, t.stop);
                if (t.stop) begin
                    wait_status(1, 1'b1, 4 * SERIAL_DIV);
                    check_bit({t.name, " rts"}, 1'b1, rts);
                    check_bit({t.name, " interrupt"}, 1'b1, user_interrupt);
                    bus_read(ADDR_DATA, word);
                    check_byte(t.name, t.expected[7:0], word[7:0]);
                end else begin
                    repeat (2 * SERIAL_DIV) @(posedge clk);  // Time for a late commit.
                end
                bus_read(ADDR_STATUS, word);
                check_bit({t.name, " valid after"}, 1'b0, word[1]);
            end
            OP_LOOP: begin
                loop_back = 1'b1;
                bus_write(ADDR_DATA, {24'd0, t.data}, ACCESS_WORD);
                wait_status(0, 1'b0, 12 * SERIAL_DIV);  // Transmitter done.
                wait_status(1, 1'b1, 2 * SERIAL_DIV);
                bus_read(ADDR_DATA, word);
                check_byte(t.name, t.expected[7:0], word[7:0]);
                loop_back = 1'b0;
            end
            default: begin
                $display("Table entry %s has no known operation", t.name);
                abort_run();
            end
        endcase
    endtask

    initial begin
        logic [7:0] b;
        rst_n = 1'b0;
        address = ADDR_STATUS;
        data_in = 32'd0;
        data_write_n = ACCESS_NONE;
        data_read_n = ACCESS_NONE;
        rxd_drv = 1'b1;
        loop_back = 1'b0;
        seed = 32'h6a015516;
        add_entry("reset values", OP_RESET, 8'h00, 32'd0, 1'b1, 32'(DIVIDER_RESET));
        add_entry("divider byte", OP_DIV_BYTE, 8'h00, 32'h3c, 1'b1, 32'h23c);  // 555 is 0x22b.
        add_entry("divider half", OP_DIV_HALF, 8'h00, 32'hffff, 1'b1, 32'h1fff);
        add_entry("divider byte 2", OP_DIV_BYTE, 8'h00, 32'h55, 1'b1, 32'h1f55);
        add_entry("divider word", OP_DIV_WORD, 8'h00, 32'habcd_8008, 1'b1, 32'h8);
        add_entry("transmit a5", OP_TX, 8'ha5, 32'd0, 1'b1, 32'ha5);
        add_entry("transmit 3e", OP_TX, 8'h3e, 32'd0, 1'b1, 32'h3e);
        add_entry("receive 5a", OP_RX, 8'h5a, 32'd0, 1'b1, 32'h5a);
        add_entry("framing error", OP_RX, 8'hc3, 32'd0, 1'b0, 32'd0);
        add_entry("overrun", OP_OVERRUN, 8'h7e, 32'd0, 1'b1, 32'h7e);
        for (int i = 0; i < 3; i++) begin
            b = 8'($random(seed));
            add_entry($sformatf("loop-back %0d", i), OP_LOOP, b, 32'd0, 1'b1, {24'd0, b});
        end
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;
        foreach (tests[i]) run_entry(tests[i]);
        $display("Verification passed");
        $finish;
    end

    // Twelve ten-bit frames per entry is far more than any entry needs.
    initial begin
        #1;
        #(tests.size() * 12 * 10 * SERIAL_DIV * 20 + 20000);
        $display("Timeout, the tests did not finish in time");
        abort_run();
    end

endmodule

`default_nettype wire

// File: verif/uart_periph_asserts.sv
// Assertions on the UART transmit and receive FSMs.
// Bound into both halves; TX_SIDE picks the set of checks.
`default_nettype none

module uart_periph_asserts #(
    parameter bit TX_SIDE = 1'b1
) (
    input logic       clk,
    input logic       rst_n,
    input logic [1:0] state,     // FSM state of the bound half.
    input logic       tx_start,
    input logic       txd,
    input logic       tx_busy,
    input logic       rx_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    import uart_pkg::*;

    if (TX_SIDE) begin : tx_checks
        idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
            state == TX_IDLE |-> txd) else $error("txd is low while the transmitter is idle");
        // A frame only begins on a request from the register block.
        busy_on_request: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(tx_busy) |-> $past(tx_start)) else $error("tx_busy rose without tx_start");
    end else begin : rx_checks
        // The flag may only rise on the edge that leaves STOP for IDLE.
        valid_on_commit: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(rx_valid) |-> state == RX_IDLE && $past(state) == RX_STOP)
            else $error("rx_valid rose outside the stop-bit commit");
    end

endmodule

bind uart_tx uart_periph_asserts #(.TX_SIDE(1'b1)) tx_asserts (
    .clk(clk), .rst_n(rst_n), .state(state), .tx_start(tx_start), .txd(txd),
    .tx_busy(tx_busy), .rx_valid(1'b0)
);

bind uart_rx uart_periph_asserts #(.TX_SIDE(1'b0)) rx_asserts (
    .clk(clk), .rst_n(rst_n), .state(state), .tx_start(1'b0), .txd(1'b1),
    .tx_busy(1'b0), .rx_valid(rx_valid)
);

`default_nettype wire

// File: compile.f
hw/uart_pkg.sv
hw/uart_baud_timer.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/uart_periph.sv
verif/uart_periph_tb.sv
verif/uart_periph_asserts.sv

// File: Makefile
TOP     := uart_periph_tb
OBJ_DIR := obj_dir

.PHONY: all build lint clean

all: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
